//--- common/core_io_pkg.sv
package core_io_pkg;

  ////////////////////
  // Bus and payload widths
  ////////////////////

  // APB side
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Descriptor channels and side inputs
  localparam int DESC_W    = 64;
  localparam int TAG_W     = 5;
  localparam int CORE_ID_W = 4;

  ////////////////////
  // Interrupts
  ////////////////////

  // Source order in irq_raw is timer, external, DRAM receive, incoming descriptor
  localparam int IRQ_N = 4;

  // Only the external interrupt is enabled out of reset
  localparam logic [IRQ_N-1:0] IRQ_MASK_RST = 4'b0010;

  // A step of one fires the timer interrupt every second cycle
  localparam logic [DATA_W-1:0] TIMER_STEP_RST = 32'd1;

  // Bit positions inside CMD and IRQ_ACK write data
  localparam int CMD_SEND_BIT    = 0;
  localparam int CMD_RELEASE_BIT = 1;
  localparam int ACK_TIMER_BIT   = 0;
  localparam int ACK_EXT_BIT     = 1;

  ////////////////////
  // Register map
  ////////////////////

  // Bit 6 of the offset splits write-only and read-only registers
  typedef enum logic [ADDR_W-1:0] {
    DESC_OUT_LO = 8'h00,
    DESC_OUT_HI = 8'h04,
    TIMER_STEP  = 8'h10,
    DRAM_FLAGS  = 8'h14,
    CMD         = 8'h20,
    FLAG_CLEAR  = 8'h24,
    IRQ_MASK    = 8'h28,
    IRQ_ACK     = 8'h2C,
    IN_DESC_LO  = 8'h40,
    IN_DESC_HI  = 8'h44,
    STATUS      = 8'h48,
    CORE_ID_REG = 8'h4C,
    TIMER_LO    = 8'h50,
    TIMER_HI    = 8'h54,
    FLAGS_RD    = 8'h58,
    IRQ_STATUS  = 8'h5C
  } io_reg_e;

endpackage

//--- desc/desc_channel.sv
`timescale 1ns/1ps

module desc_channel (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           desc_lo_wr,
  input  logic                           desc_hi_wr,
  input  logic                           cmd_wr,
  input  logic [core_io_pkg::DATA_W-1:0] wdata,
  input  logic [core_io_pkg::STRB_W-1:0] wstrb,
  input  logic                           in_desc_valid,
  input  logic                           data_desc_ready,
  output logic [core_io_pkg::DESC_W-1:0] data_desc,
  output logic                           data_desc_valid,
  output logic                           in_desc_taken
);

  logic [core_io_pkg::DESC_W-1:0]   desc_q;
  logic [core_io_pkg::DESC_W/8-1:0] lane_en;
  logic [core_io_pkg::DESC_W-1:0]   wdata_rep;
  logic                             valid_q;
  logic                             taken_q;

  ////////////////////
  // Outgoing descriptor
  ////////////////////

  // Strobes select the low or high four lanes
  // Nothing moves while a send is pending
  always_comb begin
    lane_en = '0;
    if (!valid_q) begin
      if (desc_lo_wr) begin
        lane_en = {{core_io_pkg::STRB_W{1'b0}}, wstrb};
      end else if (desc_hi_wr) begin
        lane_en = {wstrb, {core_io_pkg::STRB_W{1'b0}}};
      end
    end
  end

  assign wdata_rep = {wdata, wdata};

  always_ff @(posedge clk) begin
    for (int i = 0; i < core_io_pkg::DESC_W / 8; i++) begin
      if (lane_en[i]) begin
        desc_q[i*8 +: 8] <= wdata_rep[i*8 +: 8];
      end
    end
  end

  // Valid holds until the cycle where ready is seen with it
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (valid_q) begin
      if (data_desc_ready) begin
        valid_q <= 1'b0;
      end
    end else if (cmd_wr && wdata[core_io_pkg::CMD_SEND_BIT]) begin
      valid_q <= 1'b1;
    end
  end

  ////////////////////
  // Incoming release
  ////////////////////

  // No pulse unless a descriptor was actually offered
  always_ff @(posedge clk) begin
    if (rst) begin
      taken_q <= 1'b0;
    end else begin
      taken_q <= cmd_wr && wdata[core_io_pkg::CMD_RELEASE_BIT] && in_desc_valid;
    end
  end

  assign data_desc       = desc_q;
  assign data_desc_valid = valid_q;
  assign in_desc_taken   = taken_q;

endmodule

//--- hdl/apb_io_decode.sv
`timescale 1ns/1ps

module apb_io_decode (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [core_io_pkg::ADDR_W-1:0]    paddr,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [core_io_pkg::DATA_W-1:0]    pwdata,
  input  logic [core_io_pkg::STRB_W-1:0]    pstrb,
  input  logic [core_io_pkg::DESC_W-1:0]    desc_out_rd,
  input  logic [core_io_pkg::DESC_W-1:0]    in_desc,
  input  logic                              in_desc_valid,
  input  logic                              data_desc_valid,
  input  logic                              data_desc_ready,
  input  logic [core_io_pkg::CORE_ID_W-1:0] core_id,
  input  logic [core_io_pkg::DESC_W-1:0]    timer_value,
  input  logic [core_io_pkg::DATA_W-1:0]    flags_value,
  input  logic [core_io_pkg::IRQ_N-1:0]     irq_mask,
  input  logic [core_io_pkg::IRQ_N-1:0]     irq_raw,
  output logic [core_io_pkg::DATA_W-1:0]    prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic                              desc_lo_wr,
  output logic                              desc_hi_wr,
  output logic                              cmd_wr,
  output logic                              step_wr,
  output logic                              flags_wr,
  output logic                              flag_clr_wr,
  output logic                              mask_wr,
  output logic                              ack_wr,
  output logic [core_io_pkg::DATA_W-1:0]    wdata,
  output logic [core_io_pkg::STRB_W-1:0]    wstrb
);

  core_io_pkg::io_reg_e          reg_sel;
  logic                          access;
  logic                          setup_q;
  logic                          mapped;
  logic                          wr_ok;
  logic                          rd_ok;
  logic [core_io_pkg::DATA_W-1:0] rd_mux;

  assign reg_sel = core_io_pkg::io_reg_e'(paddr);
  assign access  = psel && penable;

  // Zero wait states, every access phase completes at once
  assign pready = access;

  // A setup phase must come first before a write may change state
  always_ff @(posedge clk) begin
    if (rst) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= psel && !penable;
    end
  end

  ////////////////////
  // Address decode
  ////////////////////

  always_comb begin
    case (reg_sel)
      core_io_pkg::DESC_OUT_LO, core_io_pkg::DESC_OUT_HI,
      core_io_pkg::TIMER_STEP,  core_io_pkg::DRAM_FLAGS,
      core_io_pkg::CMD,         core_io_pkg::FLAG_CLEAR,
      core_io_pkg::IRQ_MASK,    core_io_pkg::IRQ_ACK,
      core_io_pkg::IN_DESC_LO,  core_io_pkg::IN_DESC_HI,
      core_io_pkg::STATUS,      core_io_pkg::CORE_ID_REG,
      core_io_pkg::TIMER_LO,    core_io_pkg::TIMER_HI,
      core_io_pkg::FLAGS_RD,    core_io_pkg::IRQ_STATUS: mapped = 1'b1;
      default:                                            mapped = 1'b0;
    endcase
  end

  // Writes live in the lower half of the map, reads in the upper half
  assign wr_ok   = mapped && pwrite && !paddr[6];
  assign rd_ok   = mapped && !pwrite && paddr[6];
  assign pslverr = access && !(wr_ok || rd_ok);

  assign desc_lo_wr  = access && setup_q && wr_ok && (reg_sel == core_io_pkg::DESC_OUT_LO);
  assign desc_hi_wr  = access && setup_q && wr_ok && (reg_sel == core_io_pkg::DESC_OUT_HI);
  assign step_wr     = access && setup_q && wr_ok && (reg_sel == core_io_pkg::TIMER_STEP);
  assign flags_wr    = access && setup_q && wr_ok && (reg_sel == core_io_pkg::DRAM_FLAGS);
  assign cmd_wr      = access && setup_q && wr_ok && (reg_sel == core_io_pkg::CMD);
  assign flag_clr_wr = access && setup_q && wr_ok && (reg_sel == core_io_pkg::FLAG_CLEAR);
  assign mask_wr     = access && setup_q && wr_ok && (reg_sel == core_io_pkg::IRQ_MASK);
  assign ack_wr      = access && setup_q && wr_ok && (reg_sel == core_io_pkg::IRQ_ACK);

  assign wdata = pwdata;
  assign wstrb = pstrb;

  ////////////////////
  // Read mux
  ////////////////////

  always_comb begin
    rd_mux = '0;
    case (reg_sel)
      core_io_pkg::IN_DESC_LO:  rd_mux = in_desc_valid ? in_desc[31:0] : '0;
      core_io_pkg::IN_DESC_HI:  rd_mux = in_desc_valid ? in_desc[63:32] : '0;
      // Bit 3 tells software a nonzero descriptor is loaded
      core_io_pkg::STATUS:      rd_mux = {28'd0, (desc_out_rd != '0), data_desc_ready,
                                          data_desc_valid, in_desc_valid};
      core_io_pkg::CORE_ID_REG: rd_mux = {{(core_io_pkg::DATA_W-core_io_pkg::CORE_ID_W){1'b0}},
                                          core_id};
      core_io_pkg::TIMER_LO:    rd_mux = timer_value[31:0];
      core_io_pkg::TIMER_HI:    rd_mux = timer_value[63:32];
      core_io_pkg::FLAGS_RD:    rd_mux = flags_value;
      core_io_pkg::IRQ_STATUS:  rd_mux = {24'd0, irq_mask, irq_raw};
      default:                  rd_mux = '0;
    endcase
  end

  assign prdata = (access && rd_ok) ? rd_mux : '0;

endmodule

//--- hdl/core_io_top.sv
`timescale 1ns/1ps

module core_io_top (
  input  logic                             clk,
  input  logic                             rst,
  // APB slave
  input  logic [core_io_pkg::ADDR_W-1:0]   paddr,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [core_io_pkg::DATA_W-1:0]   pwdata,
  input  logic [core_io_pkg::STRB_W-1:0]   pstrb,
  output logic [core_io_pkg::DATA_W-1:0]   prdata,
  output logic                             pready,
  output logic                             pslverr,
  // Incoming descriptor
  input  logic [core_io_pkg::DESC_W-1:0]   in_desc,
  input  logic                             in_desc_valid,
  output logic                             in_desc_taken,
  // Outgoing descriptor
  output logic [core_io_pkg::DESC_W-1:0]   data_desc,
  output logic                             data_desc_valid,
  input  logic                             data_desc_ready,
  // DRAM receive tags
  input  logic [core_io_pkg::TAG_W-1:0]    recv_dram_tag,
  input  logic                             recv_dram_tag_valid,
  input  logic [core_io_pkg::CORE_ID_W-1:0] core_id,
  // External interrupt
  input  logic                             interrupt_in,
  output logic                             interrupt_in_ack,
  output logic                             irq
);

  logic desc_lo_wr;
  logic desc_hi_wr;
  logic cmd_wr;
  logic step_wr;
  logic flags_wr;
  logic flag_clr_wr;
  logic mask_wr;
  logic ack_wr;
  logic [core_io_pkg::DATA_W-1:0] wdata;
  logic [core_io_pkg::STRB_W-1:0] wstrb;

  logic [core_io_pkg::DESC_W-1:0] timer_value;
  logic                           timer_pending;
  logic [core_io_pkg::DATA_W-1:0] flags_value;
  logic                           dram_recv_any;
  logic [core_io_pkg::IRQ_N-1:0]  irq_mask;
  logic [core_io_pkg::IRQ_N-1:0]  irq_raw;

  apb_io_decode u_decode (
    .clk(clk), .rst(rst),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .pstrb(pstrb),
    .desc_out_rd(data_desc), .in_desc(in_desc), .in_desc_valid(in_desc_valid),
    .data_desc_valid(data_desc_valid), .data_desc_ready(data_desc_ready),
    .core_id(core_id), .timer_value(timer_value), .flags_value(flags_value),
    .irq_mask(irq_mask), .irq_raw(irq_raw),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .desc_lo_wr(desc_lo_wr), .desc_hi_wr(desc_hi_wr), .cmd_wr(cmd_wr),
    .step_wr(step_wr), .flags_wr(flags_wr), .flag_clr_wr(flag_clr_wr),
    .mask_wr(mask_wr), .ack_wr(ack_wr), .wdata(wdata), .wstrb(wstrb)
  );

  desc_channel u_desc (
    .clk(clk), .rst(rst),
    .desc_lo_wr(desc_lo_wr), .desc_hi_wr(desc_hi_wr), .cmd_wr(cmd_wr),
    .wdata(wdata), .wstrb(wstrb),
    .in_desc_valid(in_desc_valid), .data_desc_ready(data_desc_ready),
    .data_desc(data_desc), .data_desc_valid(data_desc_valid),
    .in_desc_taken(in_desc_taken)
  );

  io_timer u_timer (
    .clk(clk), .rst(rst),
    .step_wr(step_wr), .ack_wr(ack_wr), .wdata(wdata), .wstrb(wstrb),
    .timer_value(timer_value), .timer_pending(timer_pending)
  );

  dram_recv_flags u_flags (
    .clk(clk), .rst(rst),
    .recv_dram_tag(recv_dram_tag), .recv_dram_tag_valid(recv_dram_tag_valid),
    .flags_wr(flags_wr), .flag_clr_wr(flag_clr_wr), .wdata(wdata), .wstrb(wstrb),
    .flags_value(flags_value), .dram_recv_any(dram_recv_any)
  );

  irq_ctrl u_irq (
    .clk(clk), .rst(rst),
    .mask_wr(mask_wr), .ack_wr(ack_wr), .wdata(wdata),
    .timer_pending(timer_pending), .interrupt_in(interrupt_in),
    .dram_recv_any(dram_recv_any), .in_desc_valid(in_desc_valid),
    .irq_mask(irq_mask), .irq_raw(irq_raw), .irq(irq),
    .interrupt_in_ack(interrupt_in_ack)
  );

endmodule

//--- irq/dram_recv_flags.sv
`timescale 1ns/1ps

module dram_recv_flags (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [core_io_pkg::TAG_W-1:0]  recv_dram_tag,
  input  logic                           recv_dram_tag_valid,
  input  logic                           flags_wr,
  input  logic                           flag_clr_wr,
  input  logic [core_io_pkg::DATA_W-1:0] wdata,
  input  logic [core_io_pkg::STRB_W-1:0] wstrb,
  output logic [core_io_pkg::DATA_W-1:0] flags_value,
  output logic                           dram_recv_any
);

  logic [core_io_pkg::TAG_W-1:0]  tag_q;
  logic                           tag_valid_q;
  logic [core_io_pkg::DATA_W-1:0] flags_q;

  // Tag is retimed before it touches the flag word
  always_ff @(posedge clk) begin
    tag_q <= recv_dram_tag;
    if (rst) begin
      tag_valid_q <= 1'b0;
    end else begin
      tag_valid_q <= recv_dram_tag_valid;
    end
  end

  // Later statements win: an incoming tag overrides a clear of the same flag
  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q <= '0;
    end else begin
      if (flags_wr) begin
        for (int i = 0; i < core_io_pkg::STRB_W; i++) begin
          if (wstrb[i]) begin
            flags_q[i*8 +: 8] <= wdata[i*8 +: 8];
          end
        end
      end
      if (flag_clr_wr) begin
        flags_q[wdata[core_io_pkg::TAG_W-1:0]] <= 1'b0;
      end
      if (tag_valid_q) begin
        flags_q[tag_q] <= 1'b1;
      end
      flags_q[0] <= 1'b0;  // tag 0 means no buffer
    end
  end

  assign flags_value   = flags_q;
  assign dram_recv_any = |flags_q;

endmodule

//--- irq/io_timer.sv
`timescale 1ns/1ps

module io_timer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           step_wr,
  input  logic                           ack_wr,
  input  logic [core_io_pkg::DATA_W-1:0] wdata,
  input  logic [core_io_pkg::STRB_W-1:0] wstrb,
  output logic [core_io_pkg::DESC_W-1:0] timer_value,
  output logic                           timer_pending
);

  logic [core_io_pkg::DESC_W-1:0] timer_q;
  logic [core_io_pkg::DATA_W-1:0] step_q;
  logic [core_io_pkg::DATA_W-1:0] interval_q;
  logic                           pending_q;

  // Free-running time base
  always_ff @(posedge clk) begin
    if (rst) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 64'd1;
    end
  end

  // Byte-writable interval length
  always_ff @(posedge clk) begin
    if (rst) begin
      step_q <= core_io_pkg::TIMER_STEP_RST;
    end else if (step_wr) begin
      for (int i = 0; i < core_io_pkg::STRB_W; i++) begin
        if (wstrb[i]) begin
          step_q[i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // Counter wraps on a match, so the period is step plus one cycles
  always_ff @(posedge clk) begin
    if (rst || step_wr) begin
      interval_q <= '0;
      pending_q  <= 1'b0;
    end else if (interval_q == step_q) begin
      interval_q <= '0;
      pending_q  <= 1'b1;
    end else begin
      interval_q <= interval_q + 32'd1;
      if (ack_wr && wdata[core_io_pkg::ACK_TIMER_BIT]) begin
        pending_q <= 1'b0;
      end
    end
  end

  assign timer_value   = timer_q;
  assign timer_pending = pending_q;

endmodule

//--- irq/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           mask_wr,
  input  logic                           ack_wr,
  input  logic [core_io_pkg::DATA_W-1:0] wdata,
  input  logic                           timer_pending,
  input  logic                           interrupt_in,
  input  logic                           dram_recv_any,
  input  logic                           in_desc_valid,
  output logic [core_io_pkg::IRQ_N-1:0]  irq_mask,
  output logic [core_io_pkg::IRQ_N-1:0]  irq_raw,
  output logic                           irq,
  output logic                           interrupt_in_ack
);

  logic [core_io_pkg::IRQ_N-1:0] mask_q;
  logic                          ext_ack_q;

  ////////////////////
  // Mask and sources
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mask_q <= core_io_pkg::IRQ_MASK_RST;
    end else if (mask_wr) begin
      mask_q <= wdata[core_io_pkg::IRQ_N-1:0];
    end
  end

  // Timer in bit 0 up to incoming descriptor in bit 3
  assign irq_raw = {in_desc_valid, dram_recv_any, interrupt_in, timer_pending};

  assign irq      = |(irq_raw & mask_q);
  assign irq_mask = mask_q;

  ////////////////////
  // External acknowledge
  ////////////////////

  // One cycle pulse back to the external interrupt source
  always_ff @(posedge clk) begin
    if (rst) begin
      ext_ack_q <= 1'b0;
    end else begin
      ext_ack_q <= ack_wr && wdata[core_io_pkg::ACK_EXT_BIT];
    end
  end

  assign interrupt_in_ack = ext_ack_q;

endmodule

//--- src.f
common/core_io_pkg.sv
hdl/apb_io_decode.sv
desc/desc_channel.sv
irq/io_timer.sv
irq/dram_recv_flags.sv
irq/irq_ctrl.sv
hdl/core_io_top.sv
verification/core_io_checker.sv
verification/core_io_tb.sv

//--- verification/core_io_checker.sv
`timescale 1ns/1ps

module core_io_checker (
  input logic                           clk,
  input logic                           rst,
  input logic                           psel,
  input logic                           penable,
  input logic                           pready,
  input logic                           pslverr,
  input logic [core_io_pkg::DESC_W-1:0] data_desc,
  input logic                           data_desc_valid,
  input logic                           data_desc_ready,
  input logic                           in_desc_taken
);

  // Failed assertion count
  int unsigned assert_errors = 0;

  a_pready: assert property (@(posedge clk) pready == (psel && penable))
    else begin
      $error("pready differs from psel and penable");
      assert_errors++;
    end

  a_err_in_access: assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
    else begin
      $error("pslverr outside an access phase");
      assert_errors++;
    end

  // Back-pressure holds the offered descriptor
  a_desc_hold: assert property (@(posedge clk) disable iff (rst)
      data_desc_valid && !data_desc_ready |=> data_desc_valid && $stable(data_desc))
    else begin
      $error("outgoing descriptor changed under back-pressure");
      assert_errors++;
    end

  a_taken_pulse: assert property (@(posedge clk) disable iff (rst)
      in_desc_taken |=> !in_desc_taken)
    else begin
      $error("in_desc_taken held for two cycles");
      assert_errors++;
    end

endmodule

bind core_io_top core_io_checker u_checker (.*);

//--- verification/core_io_tb.sv
`timescale 1ns/1ps

module core_io_tb;

  localparam time CLK_PERIOD = 40ns;
  localparam int  TIMEOUT    = 100;

  logic                             clk;
  logic                             rst;
  logic [core_io_pkg::ADDR_W-1:0]   paddr;
  logic                             psel;
  logic                             penable;
  logic                             pwrite;
  logic [core_io_pkg::DATA_W-1:0]   pwdata;
  logic [core_io_pkg::STRB_W-1:0]   pstrb;
  logic [core_io_pkg::DATA_W-1:0]   prdata;
  logic                             pready;
  logic                             pslverr;
  logic [core_io_pkg::DESC_W-1:0]   in_desc;
  logic                             in_desc_valid;
  logic                             in_desc_taken;
  logic [core_io_pkg::DESC_W-1:0]   data_desc;
  logic                             data_desc_valid;
  logic                             data_desc_ready;
  logic [core_io_pkg::TAG_W-1:0]    recv_dram_tag;
  logic                             recv_dram_tag_valid;
  logic [core_io_pkg::CORE_ID_W-1:0] core_id;
  logic                             interrupt_in;
  logic                             interrupt_in_ack;
  logic                             irq;
  logic [31:0]                      lfsr_state;

  core_io_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("FAILED %s: expected %0h, actual %0h",
                                  name, expected, actual));
    end
  endtask

  // Stop at the first bound checker failure
  always @(negedge clk) begin
    if (u_dut.u_checker.assert_errors != 0) begin
      stop_with_failure("A checker assertion failed");
    end
  end

  // Setup phase on one falling edge and access phase on the next
  // Response sampled mid-cycle
  task automatic apb_access(input logic [7:0] addr, input logic write,
                            input logic [31:0] data, input logic [3:0] strb,
                            output logic [31:0] rdata, output logic err);
    int waited;
    paddr   = addr;
    pwrite  = write;
    pwdata  = data;
    pstrb   = strb;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    waited  = 0;
    #(CLK_PERIOD / 4);
    while (!pready) begin
      if (waited >= TIMEOUT) begin
        stop_with_failure("APB access never saw pready");
      end else begin
        @(negedge clk);
        #(CLK_PERIOD / 4);
        waited++;
      end
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic err);
    logic [31:0] unused;
    apb_access(addr, 1'b1, data, strb, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    apb_access(addr, 1'b0, '0, '0, data, err);
  endtask

  task automatic drive_tag(input logic [4:0] tag);
    recv_dram_tag       = tag;
    recv_dram_tag_valid = 1'b1;
    @(negedge clk);
    recv_dram_tag_valid = 1'b0;
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic reset_and_map();
    logic [31:0] rd;
    logic        err;
    check_value("reset irq", 0, irq);
    check_value("reset data_desc_valid", 0, data_desc_valid);
    check_value("reset in_desc_taken", 0, in_desc_taken);
    check_value("reset interrupt_in_ack", 0, interrupt_in_ack);
    apb_read(core_io_pkg::IRQ_STATUS, rd, err);
    check_value("reset irq mask", 4'b0010, rd[7:4]);
    apb_read(core_io_pkg::CORE_ID_REG, rd, err);
    check_value("core id", core_id, rd);
    check_value("core id pslverr", 0, err);
    apb_read(core_io_pkg::DESC_OUT_LO, rd, err);
    check_value("read of write register", 1, err);
    check_value("error read data", 0, rd);
    apb_write(core_io_pkg::STATUS, rand_word(), 4'hF, err);
    check_value("write of read register", 1, err);
    apb_write(8'h3C, rand_word(), 4'hF, err);
    check_value("unmapped write", 1, err);
    apb_read(8'h3C, rd, err);
    check_value("unmapped read", 1, err);
  endtask

  task automatic outgoing_descriptor();
    logic [63:0] expected;
    logic [31:0] word;
    logic        err;
    expected[31:0] = rand_word();
    apb_write(core_io_pkg::DESC_OUT_LO, expected[31:0], 4'hF, err);
    expected[63:32] = rand_word();
    apb_write(core_io_pkg::DESC_OUT_HI, expected[63:32], 4'hF, err);
    // Lanes 0 and 2 only
    word = rand_word();
    apb_write(core_io_pkg::DESC_OUT_LO, word, 4'b0101, err);
    expected[7:0]   = word[7:0];
    expected[23:16] = word[23:16];
    check_value("descriptor write pslverr", 0, err);
    check_value("descriptor merge", expected, data_desc);
    check_value("valid before send", 0, data_desc_valid);
    apb_write(core_io_pkg::CMD, 32'h1 << core_io_pkg::CMD_SEND_BIT, 4'hF, err);
    check_value("valid after send", 1, data_desc_valid);
    repeat (3) begin
      @(negedge clk);
      check_value("valid held", 1, data_desc_valid);
    end
    apb_write(core_io_pkg::DESC_OUT_LO, ~word, 4'hF, err);
    check_value("descriptor blocked", expected, data_desc);
    data_desc_ready = 1'b1;
    @(negedge clk);
    check_value("valid after handshake", 0, data_desc_valid);
    check_value("descriptor sent", expected, data_desc);
    data_desc_ready = 1'b0;
  endtask

  task automatic incoming_descriptor();
    logic [63:0] desc;
    logic [31:0] rd;
    logic        err;
    desc          = {rand_word(), rand_word()};
    in_desc       = desc;
    in_desc_valid = 1'b1;
    apb_read(core_io_pkg::IN_DESC_LO, rd, err);
    check_value("in desc low", desc[31:0], rd);
    apb_read(core_io_pkg::IN_DESC_HI, rd, err);
    check_value("in desc high", desc[63:32], rd);
    apb_read(core_io_pkg::STATUS, rd, err);
    check_value("status in valid", 1, rd[0]);
    apb_write(core_io_pkg::CMD, 32'h1 << core_io_pkg::CMD_RELEASE_BIT, 4'hF, err);
    check_value("taken pulse", 1, in_desc_taken);
    @(negedge clk);
    check_value("taken pulse end", 0, in_desc_taken);
    in_desc_valid = 1'b0;
    apb_read(core_io_pkg::IN_DESC_LO, rd, err);
    check_value("idle in desc low", 0, rd);
    apb_read(core_io_pkg::IN_DESC_HI, rd, err);
    check_value("idle in desc high", 0, rd);
    apb_write(core_io_pkg::CMD, 32'h1 << core_io_pkg::CMD_RELEASE_BIT, 4'hF, err);
    check_value("no taken when idle", 0, in_desc_taken);
    @(negedge clk);
    check_value("no taken later", 0, in_desc_taken);
  endtask

  task automatic dram_flags();
    logic [31:0] rd;
    logic        err;
    drive_tag(5'd3);
    drive_tag(5'd7);
    drive_tag(5'd0);
    repeat (2) @(negedge clk);
    apb_read(core_io_pkg::FLAGS_RD, rd, err);
    check_value("flags set", 32'h88, rd);
    apb_write(core_io_pkg::FLAG_CLEAR, 32'd3, 4'hF, err);
    apb_read(core_io_pkg::FLAGS_RD, rd, err);
    check_value("flag 3 cleared", 32'h80, rd);
    apb_write(core_io_pkg::IRQ_MASK, 32'b0100, 4'hF, err);
    check_value("dram irq", 1, irq);
    apb_write(core_io_pkg::FLAG_CLEAR, 32'd7, 4'hF, err);
    check_value("dram irq cleared", 0, irq);
  endtask

  task automatic timer_and_interrupts();
    logic [63:0] first;
    logic [63:0] second;
    logic [31:0] rd;
    logic        err;
    int          waited;
    apb_read(core_io_pkg::TIMER_LO, first[31:0], err);
    apb_read(core_io_pkg::TIMER_HI, first[63:32], err);
    apb_read(core_io_pkg::TIMER_LO, second[31:0], err);
    apb_read(core_io_pkg::TIMER_HI, second[63:32], err);
    check_value("timer increasing", 1, second > first);
    apb_write(core_io_pkg::TIMER_STEP, 32'd20, 4'hF, err);
    apb_write(core_io_pkg::IRQ_MASK, 32'b0001, 4'hF, err);
    waited = 0;
    while (!irq) begin
      if (waited >= TIMEOUT) begin
        stop_with_failure("Timer interrupt never rose");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    apb_write(core_io_pkg::IRQ_ACK, 32'h1 << core_io_pkg::ACK_TIMER_BIT, 4'hF, err);
    apb_read(core_io_pkg::IRQ_STATUS, rd, err);
    check_value("timer pending after ack", 0, rd[0]);
    check_value("irq after timer ack", 0, irq);
    apb_write(core_io_pkg::IRQ_MASK, 32'b0010, 4'hF, err);
    interrupt_in = 1'b1;
    @(negedge clk);
    check_value("external irq", 1, irq);
    interrupt_in = 1'b0;
    apb_write(core_io_pkg::IRQ_ACK, 32'h1 << core_io_pkg::ACK_EXT_BIT, 4'hF, err);
    check_value("ext ack pulse", 1, interrupt_in_ack);
    @(negedge clk);
    check_value("ext ack pulse end", 0, interrupt_in_ack);
  endtask

  initial begin
    lfsr_state          = 32'h80af5a9f;
    rst                 = 1'b1;
    paddr               = '0;
    psel                = 1'b0;
    penable             = 1'b0;
    pwrite              = 1'b0;
    pwdata              = '0;
    pstrb               = '0;
    in_desc             = '0;
    in_desc_valid       = 1'b0;
    data_desc_ready     = 1'b0;
    recv_dram_tag       = '0;
    recv_dram_tag_valid = 1'b0;
    core_id             = 4'hA;
    interrupt_in        = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    reset_and_map();
    outgoing_descriptor();
    incoming_descriptor();
    dram_flags();
    timer_and_interrupts();
    if (u_dut.u_checker.assert_errors == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      stop_with_failure($sformatf("%0d checker assertions failed",
                                  u_dut.u_checker.assert_errors));
    end
  end

endmodule
